// File: flash_ctrl_settings.svh
`ifndef FLASH_CTRL_SETTINGS_SVH
`define FLASH_CTRL_SETTINGS_SVH

// Command header
`define FLASH_ADDR_BYTES  4    // Address bytes after the opcode
`define FLASH_DUMMY_CLKS  8    // Dummy clocks before buffer read data

// Sector protection
`define FLASH_NUM_SECTORS 8
`define FLASH_SECTOR_LSB  16   // 64 KiB sectors

// Data buffer
`define FLASH_BUF_DEPTH   8
`define FLASH_BUF_AW      3    // Offset width

`endif

// File: flash_ctrl_pkg.sv
`default_nettype none
`include "flash_ctrl_settings.svh"

package flash_ctrl_pkg;

   localparam int ADDR_W = `FLASH_ADDR_BYTES * 8;
   localparam int SECT_W = $clog2(`FLASH_NUM_SECTORS);

   typedef enum logic [7:0] {
      op_wr_disable = 8'h04,
      op_rd_status  = 8'h05,
      op_wr_enable  = 8'h06,
      op_protect    = 8'h36,
      op_unprotect  = 8'h39,
      op_rd_prot    = 8'h3C,
      op_buf_write  = 8'h84,
      op_buf_read   = 8'hD4
   } opcode_e;

   typedef enum logic [2:0] {
      st_opcode,
      st_addr,
      st_dummy,
      st_send,
      st_receive,
      st_idle
   } fsm_state_e;

   typedef enum logic [1:0] {
      src_status,
      src_prot,
      src_buffer
   } tx_src_e;

   typedef struct packed {
      logic       done;   // Last bit of a byte on si
      logic [7:0] data;
   } rx_byte_t;

   // Same address word, read as a sector number or as a buffer offset
   typedef union packed {
      struct packed {
         logic [ADDR_W-`FLASH_SECTOR_LSB-SECT_W-1:0] pad_hi;
         logic [SECT_W-1:0]                          idx;
         logic [`FLASH_SECTOR_LSB-1:0]               pad_lo;
      } sector;
      struct packed {
         logic [ADDR_W-`FLASH_BUF_AW-1:0] pad;
         logic [`FLASH_BUF_AW-1:0]        offset;
      } buffer;
   } flash_addr_u;

   typedef struct packed {
      logic              set;
      logic              clr;
      logic [SECT_W-1:0] sector;
   } prot_cmd_t;

   typedef struct packed {
      logic                     en;
      logic [`FLASH_BUF_AW-1:0] offset;
      logic [7:0]               data;
   } buf_wr_t;

   typedef struct packed {
      logic    load;
      tx_src_e src;
   } tx_ctrl_t;

endpackage

`default_nettype wire

// File: spi_rx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_rx_shifter (
   input  logic                     sck,
   input  logic                     cs,
   input  logic                     si,
   output flash_ctrl_pkg::rx_byte_t rx
);

   logic [2:0] bit_cnt;
   logic [6:0] shift_q;   // First seven bits of the current byte

   always_ff @(posedge sck or posedge cs) begin
      if (cs) begin
         bit_cnt <= '0;
         shift_q <= '0;
      end else begin
         bit_cnt <= bit_cnt + 3'd1;   // Wraps every byte
         shift_q <= {shift_q[5:0], si};
      end
   end

   // The full byte is visible while its 8th bit is on si
   assign rx.done = (bit_cnt == 3'd7);
   assign rx.data = {shift_q, si};

endmodule

`default_nettype wire

// File: spi_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module spi_cmd_fsm (
   input  logic                      sck,
   input  logic                      cs,
   input  flash_ctrl_pkg::rx_byte_t  rx,
   output flash_ctrl_pkg::prot_cmd_t prot_cmd,
   output flash_ctrl_pkg::buf_wr_t   buf_wr,
   output logic [`FLASH_BUF_AW-1:0]  rd_offset,
   output flash_ctrl_pkg::tx_ctrl_t  tx_ctrl,
   output logic                      wel
);

   localparam int CNT_W       = $clog2(`FLASH_ADDR_BYTES);
   localparam int DUMMY_BYTES = `FLASH_DUMMY_CLKS / 8;

   flash_ctrl_pkg::fsm_state_e      state_q, state_d;
   flash_ctrl_pkg::opcode_e         op_q;
   flash_ctrl_pkg::flash_addr_u     addr_q, addr_d;
   flash_ctrl_pkg::tx_ctrl_t        tx_d;
   logic [CNT_W-1:0]                cnt_q, cnt_d;
   logic [`FLASH_BUF_AW-1:0]        ptr_q, ptr_d, ptr_inc;
   logic [flash_ctrl_pkg::ADDR_W-1:0] addr_word;
   logic                            wel_d;

   assign ptr_inc   = (int'(ptr_q) == `FLASH_BUF_DEPTH - 1) ? '0 : ptr_q + 1'b1;
   assign rd_offset = ptr_q;

   // Address bytes arrive MSB first
   always_comb begin
      addr_word = addr_q;
      if (state_q == flash_ctrl_pkg::st_addr) begin
         addr_word[8*(`FLASH_ADDR_BYTES-1-cnt_q) +: 8] = rx.data;
      end
      addr_d = addr_word;
   end

   always_comb begin
      state_d  = state_q;
      cnt_d    = cnt_q;
      ptr_d    = ptr_q;
      wel_d    = wel;
      tx_d     = '{load: 1'b0, src: tx_ctrl.src};
      prot_cmd = '{set: 1'b0, clr: 1'b0, sector: addr_d.sector.idx};
      buf_wr   = '{en: 1'b0, offset: ptr_q, data: rx.data};
      if (rx.done) begin
         case (state_q)
            flash_ctrl_pkg::st_opcode: begin
               cnt_d   = '0;
               state_d = flash_ctrl_pkg::st_idle;   // Unknown or refused opcode
               case (flash_ctrl_pkg::opcode_e'(rx.data))
                  flash_ctrl_pkg::op_wr_enable:  wel_d = 1'b1;
                  flash_ctrl_pkg::op_wr_disable: wel_d = 1'b0;
                  flash_ctrl_pkg::op_rd_status: begin
                     state_d = flash_ctrl_pkg::st_send;
                     tx_d    = '{load: 1'b1, src: flash_ctrl_pkg::src_status};
                  end
                  flash_ctrl_pkg::op_rd_prot,
                  flash_ctrl_pkg::op_buf_read:   state_d = flash_ctrl_pkg::st_addr;
                  flash_ctrl_pkg::op_protect,
                  flash_ctrl_pkg::op_unprotect,
                  flash_ctrl_pkg::op_buf_write: begin
                     if (wel) begin
                        state_d = flash_ctrl_pkg::st_addr;
                     end
                  end
                  default: ;
               endcase
            end
            flash_ctrl_pkg::st_addr: begin
               cnt_d = cnt_q + 1'b1;
               if (int'(cnt_q) == `FLASH_ADDR_BYTES - 1) begin
                  cnt_d   = '0;
                  state_d = flash_ctrl_pkg::st_idle;
                  case (op_q)
                     flash_ctrl_pkg::op_protect,
                     flash_ctrl_pkg::op_unprotect: begin
                        prot_cmd.set = (op_q == flash_ctrl_pkg::op_protect);
                        prot_cmd.clr = (op_q == flash_ctrl_pkg::op_unprotect);
                        wel_d        = 1'b0;   // One protection change per write enable
                     end
                     flash_ctrl_pkg::op_rd_prot: begin
                        state_d = flash_ctrl_pkg::st_send;
                        tx_d    = '{load: 1'b1, src: flash_ctrl_pkg::src_prot};
                     end
                     flash_ctrl_pkg::op_buf_read: begin
                        state_d = flash_ctrl_pkg::st_dummy;
                        ptr_d   = addr_d.buffer.offset;
                     end
                     flash_ctrl_pkg::op_buf_write: begin
                        state_d = flash_ctrl_pkg::st_receive;
                        ptr_d   = addr_d.buffer.offset;
                     end
                     default: ;
                  endcase
               end
            end
            flash_ctrl_pkg::st_dummy: begin
               cnt_d = cnt_q + 1'b1;
               if (int'(cnt_q) == DUMMY_BYTES - 1) begin
                  state_d = flash_ctrl_pkg::st_send;
                  tx_d    = '{load: 1'b1, src: flash_ctrl_pkg::src_buffer};
               end
            end
            flash_ctrl_pkg::st_send: begin
               tx_d.load = 1'b1;   // Next byte of the same source
               if (tx_ctrl.src == flash_ctrl_pkg::src_buffer) begin
                  ptr_d = ptr_inc;
               end
            end
            flash_ctrl_pkg::st_receive: begin
               buf_wr.en = 1'b1;
               ptr_d     = ptr_inc;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge sck or posedge cs) begin
      if (cs) begin
         state_q <= flash_ctrl_pkg::st_opcode;
         cnt_q   <= '0;
         tx_ctrl <= '{load: 1'b0, src: flash_ctrl_pkg::src_status};
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         tx_ctrl <= tx_d;
      end
   end

   // WEL survives cs like the rest of the device state
   always_ff @(posedge sck) begin
      wel    <= wel_d;
      ptr_q  <= ptr_d;
      addr_q <= addr_d;
      if (state_q == flash_ctrl_pkg::st_opcode && rx.done) begin
         op_q <= flash_ctrl_pkg::opcode_e'(rx.data);
      end
   end

endmodule

`default_nettype wire

// File: sector_prot_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module sector_prot_regs (
   input  logic                      sck,
   input  flash_ctrl_pkg::prot_cmd_t prot_cmd,
   output logic                      is_protected
);

   logic [`FLASH_NUM_SECTORS-1:0] prot_q;   // One bit per sector

   always_ff @(posedge sck) begin
      if (prot_cmd.set) begin
         prot_q[prot_cmd.sector] <= 1'b1;
      end else if (prot_cmd.clr) begin
         prot_q[prot_cmd.sector] <= 1'b0;
      end
   end

   // Follows the addressed sector, also right after the address ends
   assign is_protected = prot_q[prot_cmd.sector];

endmodule

`default_nettype wire

// File: data_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module data_buffer (
   input  logic                     sck,
   input  flash_ctrl_pkg::buf_wr_t  buf_wr,
   input  logic [`FLASH_BUF_AW-1:0] rd_offset,
   output logic [7:0]               rd_data
);

   logic [7:0] mem [`FLASH_BUF_DEPTH];

   always_ff @(posedge sck) begin
      if (buf_wr.en) begin
         mem[buf_wr.offset] <= buf_wr.data;
      end
   end

   // Read is combinational so tx can load in the same cycle
   assign rd_data = mem[rd_offset];

endmodule

`default_nettype wire

// File: spi_tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tx_shifter (
   input  logic                     sck,
   input  logic                     cs,
   input  flash_ctrl_pkg::tx_ctrl_t tx_ctrl,
   input  logic                     wel,
   input  logic                     is_protected,
   input  logic [7:0]               buf_data,
   output logic                     so
);

   logic [7:0] tx_byte;
   logic [7:0] shift_q;

   always_comb begin
      case (tx_ctrl.src)
         flash_ctrl_pkg::src_status: tx_byte = {6'b0, wel, 1'b0};
         flash_ctrl_pkg::src_prot:   tx_byte = {8{is_protected}};   // FFh or 00h
         flash_ctrl_pkg::src_buffer: tx_byte = buf_data;
         default:                    tx_byte = 8'h00;
      endcase
   end

   // The MSB goes out directly in the load cycle, the rest from the register
   always_ff @(posedge sck or posedge cs) begin
      if (cs) begin
         shift_q <= '0;
      end else if (tx_ctrl.load) begin
         shift_q <= {tx_byte[6:0], 1'b0};
      end else begin
         shift_q <= {shift_q[6:0], 1'b0};   // Drains to zero when idle
      end
   end

   assign so = tx_ctrl.load ? tx_byte[7] : shift_q[7];

endmodule

`default_nettype wire

// File: spi_flash_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module spi_flash_ctrl (
   input  logic sck,
   input  logic cs,
   input  logic si,
   output logic so
);

   flash_ctrl_pkg::rx_byte_t  rx;
   flash_ctrl_pkg::prot_cmd_t prot_cmd;
   flash_ctrl_pkg::buf_wr_t   buf_wr;
   flash_ctrl_pkg::tx_ctrl_t  tx_ctrl;
   logic [`FLASH_BUF_AW-1:0]  rd_offset;
   logic [7:0]                buf_data;
   logic                      wel;
   logic                      is_protected;

   spi_rx_shifter u_rx (
      .sck (sck),
      .cs  (cs),
      .si  (si),
      .rx  (rx)
   );

   spi_cmd_fsm u_fsm (
      .sck       (sck),
      .cs        (cs),
      .rx        (rx),
      .prot_cmd  (prot_cmd),
      .buf_wr    (buf_wr),
      .rd_offset (rd_offset),
      .tx_ctrl   (tx_ctrl),
      .wel       (wel)
   );

   sector_prot_regs u_prot (
      .sck          (sck),
      .prot_cmd     (prot_cmd),
      .is_protected (is_protected)
   );

   data_buffer u_buf (
      .sck       (sck),
      .buf_wr    (buf_wr),
      .rd_offset (rd_offset),
      .rd_data   (buf_data)
   );

   spi_tx_shifter u_tx (
      .sck          (sck),
      .cs           (cs),
      .tx_ctrl      (tx_ctrl),
      .wel          (wel),
      .is_protected (is_protected),
      .buf_data     (buf_data),
      .so           (so)
   );

endmodule

`default_nettype wire

// File: spi_flash_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_ctrl_sva (
   input logic                       sck,
   input logic                       cs,
   input flash_ctrl_pkg::prot_cmd_t  prot_cmd,
   input flash_ctrl_pkg::buf_wr_t    buf_wr,
   input flash_ctrl_pkg::tx_ctrl_t   tx_ctrl,
   input flash_ctrl_pkg::fsm_state_e state_q
);

   int fail_count = 0;

   no_pulse_while_cs: assert property (@(posedge sck)
      cs |-> !(prot_cmd.set || prot_cmd.clr || buf_wr.en || tx_ctrl.load))
   else begin
      fail_count++;
      $error("Command pulse while cs is high");
   end

   set_clr_exclusive: assert property (@(posedge sck) !(prot_cmd.set && prot_cmd.clr))
   else begin
      fail_count++;
      $error("Sector set and clear in the same cycle");
   end

   load_in_send: assert property (@(posedge sck)
      tx_ctrl.load |-> state_q == flash_ctrl_pkg::st_send)
   else begin
      fail_count++;
      $error("Transmit load outside the send state");
   end

endmodule

bind spi_cmd_fsm spi_flash_ctrl_sva u_sva (
   .sck      (sck),
   .cs       (cs),
   .prot_cmd (prot_cmd),
   .buf_wr   (buf_wr),
   .tx_ctrl  (tx_ctrl),
   .state_q  (state_q)
);

`default_nettype wire

// File: spi_flash_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module spi_flash_checker (
   input  logic sck,
   input  logic cs,
   input  logic si,
   input  logic so,
   output int   byte_checks,
   output int   error_count
);

   logic [7:0]  mdl_buf [`FLASH_BUF_DEPTH];
   logic        mdl_prot [`FLASH_NUM_SECTORS];
   logic        mdl_wel;
   logic [7:0]  op;
   logic [7:0]  rx_shift;
   logic [31:0] addr;
   logic        granted;    // WEL when the opcode arrived
   int          sector;
   int          ptr;
   int          edge_no;    // Rising edges since cs fell
   int          hdr_len;    // Zero when nothing is returned
   int          out_pos;
   logic [7:0]  out_byte;
   logic        exp_bit;
   logic [7:0]  got_acc;
   logic [7:0]  exp_acc;
   int          acc_bits;

   function automatic logic [7:0] expected_byte(input logic [7:0] opcode, input int index);
      case (opcode)
         8'h05:   return mdl_wel ? 8'h02 : 8'h00;
         8'h3C:   return mdl_prot[index] ? 8'hFF : 8'h00;
         8'hD4:   return mdl_buf[index % `FLASH_BUF_DEPTH];
         default: return 8'h00;
      endcase
   endfunction

   task automatic take_byte(input logic [7:0] b, input int k);
      if (k == 0) begin
         op      = b;
         granted = mdl_wel;
         hdr_len = (b == 8'h05) ? 8 : 0;
         if (b == 8'h06) mdl_wel = 1'b1;
         if (b == 8'h04) mdl_wel = 1'b0;
      end else if (k <= `FLASH_ADDR_BYTES) begin
         addr = {addr[23:0], b};
         if (k == `FLASH_ADDR_BYTES) begin
            sector = addr[`FLASH_SECTOR_LSB +: flash_ctrl_pkg::SECT_W];
            ptr    = addr[`FLASH_BUF_AW-1:0];
            if ((op == 8'h36 || op == 8'h39) && granted) begin
               mdl_prot[sector] = (op == 8'h36);
               mdl_wel          = 1'b0;
            end
            if (op == 8'h3C) hdr_len = 40;
            if (op == 8'hD4) hdr_len = 48;   // Address plus dummy byte
         end
      end else if (op == 8'h84 && granted) begin
         mdl_buf[ptr] = b;
         ptr          = (ptr + 1) % `FLASH_BUF_DEPTH;
      end
   endtask

   task automatic compare_slot();
      byte_checks++;
      if (got_acc !== exp_acc) begin
         error_count++;
         $display("CHECK FAILED at %0t: opcode %02h byte %0d on so is %02h, expected %02h",
                  $time, op, edge_no / 8, got_acc, exp_acc);
      end
      got_acc  = '0;
      exp_acc  = '0;
      acc_bits = 0;
   endtask

   initial begin
      byte_checks = 0;
      error_count = 0;
      mdl_wel     = 1'b0;
      edge_no     = 0;
      hdr_len     = 0;
      exp_bit     = 1'b0;
      got_acc     = '0;
      exp_acc     = '0;
      acc_bits    = 0;
      for (int i = 0; i < `FLASH_BUF_DEPTH; i++) mdl_buf[i] = '0;
      for (int i = 0; i < `FLASH_NUM_SECTORS; i++) mdl_prot[i] = 1'b0;
   end

   always @(posedge sck) begin
      if (cs) begin
         if (acc_bits > 0) compare_slot();   // Last byte cut by cs
         edge_no = 0;
         hdr_len = 0;
         exp_bit = 1'b0;
      end else begin
         edge_no++;
         rx_shift = {rx_shift[6:0], si};
         if (edge_no % 8 == 0) take_byte(rx_shift, edge_no / 8 - 1);
         exp_bit = 1'b0;
         if (hdr_len != 0 && edge_no >= hdr_len) begin
            out_pos  = edge_no - hdr_len;
            out_byte = expected_byte(op, (op == 8'h3C) ? sector : ptr + out_pos / 8);
            exp_bit  = out_byte[7 - out_pos % 8];
         end
      end
   end

   always @(negedge sck) begin
      if (!cs) begin
         got_acc = {got_acc[6:0], so};
         exp_acc = {exp_acc[6:0], exp_bit};
         acc_bits++;
         if (edge_no % 8 == 7) compare_slot();
      end
   end

endmodule

`default_nettype wire

// File: tb_spi_flash_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "flash_ctrl_settings.svh"

module tb_spi_flash_ctrl;

   localparam int CLK_PERIOD = 40;
   localparam int TEST_BITS  = 2150;   // Command bits plus cs gaps of the sequence below

   logic sck;
   logic cs;
   logic si;
   logic so;
   int   seed;
   int   byte_checks;
   int   error_count;
   int   sa;
   int   sb;

   spi_flash_ctrl DUT (
      .sck (sck),
      .cs  (cs),
      .si  (si),
      .so  (so)
   );

   spi_flash_checker u_check (
      .sck         (sck),
      .cs          (cs),
      .si          (si),
      .so          (so),
      .byte_checks (byte_checks),
      .error_count (error_count)
   );

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   // Random padding around the sector index
   function automatic logic [31:0] sector_addr(input int sector);
      logic [31:0] a;
      a = rand_word();
      a[`FLASH_SECTOR_LSB +: flash_ctrl_pkg::SECT_W] = sector;
      return a;
   endfunction

   task automatic send_bits(input logic [31:0] value, input int nbits);
      for (int i = nbits - 1; i >= 0; i--) begin
         @(negedge sck);
         cs <= 1'b0;
         si <= value[i];
      end
   endtask

   task automatic end_cmd();
      @(negedge sck);
      cs <= 1'b1;   // Two full cycles high between commands
      si <= 1'b0;
      @(negedge sck);
   endtask

   task automatic run_cmd(input logic [7:0] op, input logic [31:0] addr, input int nbytes);
      send_bits(op, 8);
      if (op inside {8'h36, 8'h39, 8'h3C, 8'hD4}) begin
         send_bits(addr, 32);
      end
      if (op == 8'hD4) begin
         send_bits('0, `FLASH_DUMMY_CLKS);
      end
      repeat (nbytes) send_bits('0, 8);
      end_cmd();
   endtask

   task automatic buf_write(input int offset, input int nbytes, input int tail_bits);
      logic [31:0] addr;
      addr = rand_word();
      addr[`FLASH_BUF_AW-1:0] = offset;
      send_bits(8'h84, 8);
      send_bits(addr, 32);
      repeat (nbytes) send_bits(rand_word(), 8);
      send_bits(rand_word(), tail_bits);   // Unfinished byte
      end_cmd();
   endtask

   initial begin
      sck = 1'b0;
      forever #(CLK_PERIOD / 2) sck = ~sck;
   end

   initial begin
      #(2 * TEST_BITS * CLK_PERIOD + 10 * CLK_PERIOD);
      $display("Timeout: the command sequence did not complete in the expected time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      cs   = 1'b0;
      si   = 1'b0;
      seed = 32'hb3eb;
      #1 cs = 1'b1;
      repeat (10) @(negedge sck);
      // Persistent state has no reset, so set it up by commands
      run_cmd(8'h04, '0, 0);
      for (int s = 0; s < `FLASH_NUM_SECTORS; s++) begin
         run_cmd(8'h06, '0, 0);
         run_cmd(8'h39, sector_addr(s), 0);
      end
      run_cmd(8'h06, '0, 0);
      buf_write(0, `FLASH_BUF_DEPTH, 0);
      run_cmd(8'h06, '0, 0);
      run_cmd(8'h05, '0, 4);
      run_cmd(8'h04, '0, 0);
      run_cmd(8'h05, '0, 4);
      sa = rand_word() % `FLASH_NUM_SECTORS;
      run_cmd(8'h36, sector_addr(sa), 0);   // Refused while WEL is clear
      run_cmd(8'h3C, sector_addr(sa), 2);
      run_cmd(8'h06, '0, 0);
      run_cmd(8'h36, sector_addr(sa), 0);
      run_cmd(8'h3C, sector_addr(sa), 2);
      run_cmd(8'h05, '0, 2);
      sb = (sa + 1 + rand_word() % 7) % `FLASH_NUM_SECTORS;
      run_cmd(8'h06, '0, 0);
      run_cmd(8'h36, sector_addr(sb), 0);
      run_cmd(8'h06, '0, 0);
      run_cmd(8'h39, sector_addr(sa), 0);
      for (int s = 0; s < `FLASH_NUM_SECTORS; s++) begin
         run_cmd(8'h3C, sector_addr(s), 1);
      end
      run_cmd(8'h06, '0, 0);
      buf_write(rand_word() % `FLASH_BUF_DEPTH, 11, 0);
      run_cmd(8'hD4, rand_word(), 10);
      run_cmd(8'hD4, rand_word(), 3);
      run_cmd(8'h04, '0, 0);
      buf_write(rand_word() % `FLASH_BUF_DEPTH, 4, 0);
      run_cmd(8'hD4, '0, 8);
      run_cmd(8'hA5, '0, 4);   // Not a known opcode
      run_cmd(8'h06, '0, 0);
      buf_write(rand_word() % `FLASH_BUF_DEPTH, 1, 5);
      run_cmd(8'hD4, '0, 8);
      repeat (4) @(negedge sck);
      $display("Checks: %0d bytes compared, %0d mismatches, %0d assertion failures",
               byte_checks, error_count, DUT.u_fsm.u_sva.fail_count);
      if (error_count == 0 && DUT.u_fsm.u_sva.fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
flash_ctrl_pkg.sv
spi_rx_shifter.sv
spi_cmd_fsm.sv
sector_prot_regs.sv
data_buffer.sv
spi_tx_shifter.sv
spi_flash_ctrl.sv
spi_flash_ctrl_sva.sv
spi_flash_checker.sv
tb_spi_flash_ctrl.sv

// File: Bender.yml
package:
  name: spi_flash_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - flash_ctrl_pkg.sv
      - spi_rx_shifter.sv
      - spi_cmd_fsm.sv
      - sector_prot_regs.sv
      - data_buffer.sv
      - spi_tx_shifter.sv
      - spi_flash_ctrl.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - spi_flash_ctrl_sva.sv
      - spi_flash_checker.sv
      - tb_spi_flash_ctrl.sv
